// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  // one bit per byte lane
  typedef logic [xlen/8-1:0] strb_t;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    op_load     = 7'b00_000_11,
    op_store    = 7'b01_000_11,
    op_branch   = 7'b11_000_11,
    op_jalr     = 7'b11_001_11,
    op_misc_mem = 7'b00_011_11,
    op_jal      = 7'b11_011_11,
    op_reg_imm  = 7'b00_100_11,
    op_reg_reg  = 7'b01_100_11,
    op_system   = 7'b11_100_11,
    op_auipc    = 7'b00_101_11,
    op_lui      = 7'b01_101_11
  } opcode_e;

  // compare ops return 1 or 0 in bit 0
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_seq,
    alu_sne,
    alu_sge,
    alu_sgeu,
    alu_pass_b
  } alu_op_e;

  // encoded like funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte = 2'd0,
    mem_half = 2'd1,
    mem_word = 2'd2
  } mem_size_e;

  typedef enum logic [2:0] {
    pc_plus4,
    pc_branch,
    pc_jal,
    pc_jalr,
    pc_hold
  } pc_sel_e;

  typedef enum logic {
    op_a_rs1,
    op_a_pc
  } op_a_sel_e;

  // addi x0, x0, 0
  localparam word_t nop_insn = 32'h0000_0013;

endpackage

`default_nettype wire

// File: hw/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t      insn,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output word_t      imm,
  output alu_op_e    alu_op,
  output op_a_sel_e  op_a_sel,
  output logic       use_imm,
  output mem_size_e  mem_size,
  output logic       mem_unsigned,
  output logic       mem_load,
  output logic       mem_store,
  output logic       reg_write,
  output logic       wb_link,
  output pc_sel_e    pc_sel,
  output logic       halt
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_op_e    base_op;
  logic       illegal;
  logic       is_ecall;

  assign opcode  = opcode_e'(insn[6:0]);
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign f7_zero = (funct7 == 7'b000_0000);
  assign f7_alt  = (funct7 == 7'b010_0000);

  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];
  assign rd  = insn[11:7];

  // sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // shared funct3 mapping for reg-imm and reg-reg
  always_comb begin
    case (funct3)
      3'b000:  base_op = alu_add;
      3'b001:  base_op = alu_sll;
      3'b010:  base_op = alu_slt;
      3'b011:  base_op = alu_sltu;
      3'b100:  base_op = alu_xor;
      3'b101:  base_op = insn[30] ? alu_sra : alu_srl;
      3'b110:  base_op = alu_or;
      default: base_op = alu_and;
    endcase
  end

  always_comb begin
    imm          = imm_i;
    alu_op       = alu_add;
    op_a_sel     = op_a_rs1;
    use_imm      = 1'b0;
    mem_size     = mem_size_e'(funct3[1:0]);
    mem_unsigned = funct3[2];
    mem_load     = 1'b0;
    mem_store    = 1'b0;
    reg_write    = 1'b0;
    wb_link      = 1'b0;
    pc_sel       = pc_plus4;
    illegal      = 1'b0;
    is_ecall     = 1'b0;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        op_a_sel  = op_a_pc;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        reg_write = 1'b1;
        wb_link   = 1'b1;
        pc_sel    = pc_jal;
      end
      op_jalr: begin
        reg_write = 1'b1;
        wb_link   = 1'b1;
        pc_sel    = pc_jalr;
        illegal   = (funct3 != 3'b000);
      end
      op_branch: begin
        imm    = imm_b;
        pc_sel = pc_branch;
        case (funct3)
          3'b000:  alu_op = alu_seq;
          3'b001:  alu_op = alu_sne;
          3'b100:  alu_op = alu_slt;
          3'b101:  alu_op = alu_sge;
          3'b110:  alu_op = alu_sltu;
          3'b111:  alu_op = alu_sgeu;
          default: illegal = 1'b1;
        endcase
      end
      op_load: begin
        use_imm   = 1'b1;
        mem_load  = 1'b1;
        reg_write = 1'b1;
        // lb lh lw lbu lhu only
        illegal   = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      op_store: begin
        imm       = imm_s;
        use_imm   = 1'b1;
        mem_store = 1'b1;
        illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      op_reg_imm: begin
        alu_op    = base_op;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        // shift amounts carry funct7 in the upper immediate bits
        if (funct3 == 3'b001) begin
          illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(f7_zero || f7_alt);
        end
      end
      op_reg_reg: begin
        alu_op    = (funct3 == 3'b000 && insn[30]) ? alu_sub : base_op;
        reg_write = 1'b1;
        illegal   = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      op_misc_mem: begin
        // fence, nothing to order in this core
      end
      op_system: begin
        is_ecall = (insn[31:7] == 25'd0);
        illegal  = !is_ecall;
      end
      default: illegal = 1'b1;
    endcase

    halt = is_ecall || illegal;
    if (halt) begin
      reg_write = 1'b0;
      mem_load  = 1'b0;
      mem_store = 1'b0;
      pc_sel    = pc_hold;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  // x0 has no storage
  word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = (a == b);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      // set-if results, bit 0 also drives branch_taken
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
      alu_seq:    result = {{(xlen-1){1'b0}}, eq};
      alu_sne:    result = {{(xlen-1){1'b0}}, !eq};
      alu_sge:    result = {{(xlen-1){1'b0}}, !lt_s};
      alu_sgeu:   result = {{(xlen-1){1'b0}}, !lt_u};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_lsu.sv
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  word_t     addr,
  input  word_t     store_data,
  input  word_t     mem_rdata,
  input  mem_size_e size,
  input  logic      is_unsigned,
  input  logic      load,
  input  logic      store,
  output word_t     mem_addr,
  output word_t     mem_wdata,
  output word_t     load_data,
  output strb_t     mem_strb
);

  logic [1:0]  offset;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  word_t       extracted;
  strb_t       strb_raw;

  assign offset   = addr[1:0];
  assign mem_addr = {addr[xlen-1:2], 2'b00};

  // half picks by offset[1], misaligned low bit ignored
  assign lane_byte = mem_rdata[{offset, 3'b000} +: 8];
  assign lane_half = mem_rdata[{offset[1], 4'b0000} +: 16];

  always_comb begin
    case (size)
      mem_byte: extracted = {{24{lane_byte[7] & !is_unsigned}}, lane_byte};
      mem_half: extracted = {{16{lane_half[15] & !is_unsigned}}, lane_half};
      default:  extracted = mem_rdata;
    endcase
  end

  assign load_data = load ? extracted : '0;

  // replicate into every lane, strobes pick the right one
  always_comb begin
    case (size)
      mem_byte: begin
        mem_wdata = {4{store_data[7:0]}};
        strb_raw  = strb_t'(4'b0001 << offset);
      end
      mem_half: begin
        mem_wdata = {2{store_data[15:0]}};
        strb_raw  = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mem_wdata = store_data;
        strb_raw  = 4'b1111;
      end
    endcase
  end

  assign mem_strb = store ? strb_raw : '0;

endmodule

`default_nettype wire

// File: hw/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic    clk,
  input  logic    rst,
  input  pc_sel_e sel,
  input  word_t   imm,
  input  word_t   jalr_base,
  input  logic    branch_taken,
  output word_t   pc,
  output word_t   pc_plus4
);

  word_t pc_target;
  word_t jalr_sum;
  word_t pc_next;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign jalr_sum  = jalr_base + imm;

  always_comb begin
    case (sel)
      pc_branch: pc_next = branch_taken ? pc_target : pc_plus4;
      pc_jal:    pc_next = pc_target;
      // target lsb is always cleared for jalr
      pc_jalr:   pc_next = {jalr_sum[xlen-1:1], 1'b0};
      pc_hold:   pc_next = pc;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  word_t imem_data,
  input  word_t dmem_rdata,
  output word_t imem_addr,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output strb_t dmem_strb,
  output logic  halt
);

  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  word_t     imm;
  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  logic      use_imm;
  mem_size_e mem_size;
  logic      mem_unsigned;
  logic      mem_load;
  logic      mem_store;
  logic      reg_write;
  logic      wb_link;
  pc_sel_e   pc_sel;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  word_t     load_data;
  word_t     pc_plus4;
  word_t     rd_data;

  rv_decoder decoder_inst (
    .insn         (imem_data),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .imm          (imm),
    .alu_op       (alu_op),
    .op_a_sel     (op_a_sel),
    .use_imm      (use_imm),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned),
    .mem_load     (mem_load),
    .mem_store    (mem_store),
    .reg_write    (reg_write),
    .wb_link      (wb_link),
    .pc_sel       (pc_sel),
    .halt         (halt)
  );

  // no retirement once halted
  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_write && !halt),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = (op_a_sel == op_a_pc) ? imem_addr : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu alu_inst (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_lsu lsu_inst (
    .addr        (alu_result),
    .store_data  (rs2_data),
    .mem_rdata   (dmem_rdata),
    .size        (mem_size),
    .is_unsigned (mem_unsigned),
    .load        (mem_load),
    .store       (mem_store),
    .mem_addr    (dmem_addr),
    .mem_wdata   (dmem_wdata),
    .load_data   (load_data),
    .mem_strb    (dmem_strb)
  );

  // link for jumps, else load or alu result
  assign rd_data = wb_link  ? pc_plus4 :
                   mem_load ? load_data : alu_result;

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) pc_unit_inst (
    .clk          (clk),
    .rst          (rst),
    .sel          (pc_sel),
    .imm          (imm),
    .jalr_base    (rs1_data),
    .branch_taken (alu_result[0]),
    .pc           (imem_addr),
    .pc_plus4     (pc_plus4)
  );

endmodule

`default_nettype wire

// File: verif/rv_mem_model.sv
`default_nettype none

module rv_mem_model import rv_pkg::*; (
  input  logic  clk,
  input  logic  load_en,
  input  word_t load_addr,
  input  word_t load_data,
  input  word_t imem_addr,
  output word_t imem_data,
  input  word_t dmem_addr,
  input  word_t dmem_wdata,
  input  strb_t dmem_strb,
  output word_t dmem_rdata,
  input  word_t peek_addr,
  output word_t peek_data
);

  word_t mem [0:1023];

  // fill depends on every address bit
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5a5a_0000 ^ (i * 32'h9e37_79b1);
    end
  end

  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];
  assign peek_data  = mem[peek_addr[11:2]];

  // program loader has priority over core stores
  always @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[11:2]] <= load_data;
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_strb[k]) begin
          mem[dmem_addr[11:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/rv_core_tb.sv
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  localparam word_t start_pc = 32'd256;
  localparam word_t data_base = 32'h600;
  localparam int prog_words = 96;
  localparam int cycle_limit = 6 * 200;

  logic  clk;
  logic  rst;
  logic  load_en;
  word_t load_addr;
  word_t load_data;
  word_t peek_addr;
  word_t peek_data;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;
  strb_t dmem_strb;
  logic  halt;

  string test_name;
  word_t prog [$];
  strb_t strb_log [$];
  word_t addr_log [$];
  word_t data_log [$];
  int    cycles;
  int    seed;

  rv_core #(.reset_pc(start_pc)) rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (dmem_strb),
    .halt       (halt)
  );

  rv_mem_model mem_inst (
    .clk        (clk),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (dmem_strb),
    .dmem_rdata (dmem_rdata),
    .peek_addr  (peek_addr),
    .peek_data  (peek_data)
  );

  always #5 clk = ~clk;

  // every store the core makes, seen at its ports
  always @(posedge clk) begin
    if (!rst && dmem_strb != '0) begin
      strb_log.push_back(dmem_strb);
      addr_log.push_back(dmem_addr);
      data_log.push_back(dmem_wdata);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout in test %s: core did not halt within %0d cycles", test_name, cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd31, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic word_t cur_pc();
    return start_pc + 4 * prog.size();
  endfunction

  // RV32I branch conditions by funct3
  function automatic logic branch_rule(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // logical shift with the sign copied into the vacated bits
  function automatic word_t shift_arith(word_t v, logic [4:0] s);
    word_t fill;
    fill = v[31] ? ~(32'hffff_ffff >> s) : 32'd0;
    return (v >> s) | fill;
  endfunction

  function automatic word_t extend(word_t raw, int bits, logic uns);
    word_t v;
    v = (bits == 8) ? {24'd0, raw[7:0]} : {16'd0, raw[15:0]};
    if (!uns && raw[bits-1]) begin
      v = v | (32'hffff_ffff << bits);
    end
    return v;
  endfunction

  // byte lanes enabled by a strobe vector
  function automatic word_t lane_mask(strb_t s);
    word_t m;
    for (int k = 0; k < 4; k++) begin
      m[8*k +: 8] = {8{s[k]}};
    end
    return m;
  endfunction

  task automatic emit(word_t w);
    prog.push_back(w);
  endtask

  // always two words so pc arithmetic stays simple
  task automatic emit_li(reg_idx_t rd, word_t v);
    word_t up;
    up = v + 32'h800;
    emit(enc_u(up[31:12], rd, op_lui));
    emit(enc_i(v[11:0], rd, 3'b000, rd, op_reg_imm));
  endtask

  task automatic emit_sw(reg_idx_t rs2, int off);
    emit(enc_s(off[11:0], rs2, 3'b010));
  endtask

  task automatic start_test(string name);
    test_name = name;
    prog.delete();
    emit(enc_i(data_base[11:0], 5'd0, 3'b000, 5'd31, op_reg_imm));
  endtask

  task automatic fail_plain(string msg);
    $display("Error in test %s: %s", test_name, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(string what, word_t exp, word_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_strb(string what, strb_t exp, strb_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // loads the program with the core held in reset
  task automatic load_and_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < prog_words; i++) begin
      load_en   = 1'b1;
      load_addr = start_pc + 4 * i;
      load_data = (i < prog.size()) ? prog[i] : nop_insn;
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    strb_log.delete();
    addr_log.delete();
    data_log.delete();
  endtask

  task automatic run_to_halt();
    while (halt !== 1'b1) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic read_word(input word_t addr, output word_t data);
    peek_addr = addr;
    #1;
    data = peek_data;
  endtask

  task automatic check_slots(word_t exp [$]);
    word_t got;
    for (int k = 0; k < exp.size(); k++) begin
      read_word(data_base + 4 * k, got);
      check_word($sformatf("slot %0d", k), exp[k], got);
    end
  endtask

  task automatic test_reset();
    start_test("reset");
    emit(32'h0000_0073);
    load_and_reset();
    check_word("pc after reset", start_pc, imem_addr);
    check_strb("strb after reset", 4'b0000, dmem_strb);
    check_bit("halt after reset", 1'b0, halt);
    @(posedge clk);
    #1;
    check_word("pc one cycle later", start_pc + 4, imem_addr);
    run_to_halt();
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    word_t e [$];
    logic [11:0] imm;
    logic [4:0] sh;
    logic [2:0] f3s [10] = '{0, 0, 4, 6, 7, 1, 5, 5, 2, 3};
    logic [6:0] f7s [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};
    a = $random(seed);
    b = $random(seed);
    imm = 12'($random(seed));
    sh = 5'($random(seed));
    e = '{a + b, a - b, a ^ b, a | b, a & b, a << b[4:0], a >> b[4:0],
          shift_arith(a, b[4:0]), {31'd0, $signed(a) < $signed(b)}, {31'd0, a < b}};
    start_test("alu");
    emit_li(1, a);
    emit_li(2, b);
    for (int k = 0; k < 10; k++) begin
      emit(enc_r(f7s[k], 2, 1, f3s[k], 3));
      emit_sw(3, 4 * k);
    end
    emit(enc_i(imm, 1, 3'b000, 3, op_reg_imm));
    emit_sw(3, 40);
    e.push_back(a + {{20{imm[11]}}, imm});
    emit(enc_i({7'h20, sh}, 1, 3'b101, 3, op_reg_imm));
    emit_sw(3, 44);
    e.push_back(shift_arith(a, sh));
    // write to x0 must be dropped
    emit(enc_i(12'd5, 1, 3'b000, 0, op_reg_imm));
    emit_sw(0, 48);
    e.push_back(32'd0);
    emit(32'h0000_0073);
    load_and_reset();
    run_to_halt();
    check_slots(e);
  endtask

  task automatic test_jumps();
    word_t pc_a;
    word_t pc_j;
    word_t pc_r;
    word_t e [$];
    start_test("jumps");
    emit_li(8, 32'h55);
    emit_sw(0, 16);
    emit_sw(0, 20);
    emit(enc_u(20'habcde, 5, op_lui));
    pc_a = cur_pc();
    emit(enc_u(20'h00012, 6, op_auipc));
    pc_j = cur_pc();
    emit(enc_j(21'd8, 7));
    emit_sw(8, 16);
    // odd target checks that jalr clears bit 0
    emit_li(9, cur_pc() + 16 + 1);
    pc_r = cur_pc();
    emit(enc_i(12'd0, 9, 3'b000, 10, op_jalr));
    emit_sw(8, 20);
    emit_sw(5, 0);
    emit_sw(6, 4);
    emit_sw(7, 8);
    emit_sw(10, 12);
    emit(32'h0000_0073);
    e = '{32'habcd_e000, pc_a + 32'h12000, pc_j + 4, pc_r + 4, 0, 0};
    load_and_reset();
    run_to_halt();
    check_slots(e);
  endtask

  task automatic test_branches();
    logic [2:0] f3s [6] = '{0, 1, 4, 5, 6, 7};
    reg_idx_t ra [3] = '{1, 2, 1};
    reg_idx_t rb [3] = '{2, 1, 1};
    word_t val [3] = '{32'hffff_fffb, 32'd3, 32'hffff_fffb};
    word_t valb [3] = '{32'd3, 32'hffff_fffb, 32'hffff_fffb};
    word_t e [$];
    int k;
    start_test("branches");
    emit_li(1, 32'hffff_fffb);
    emit_li(2, 32'd3);
    emit_li(11, 32'd1);
    k = 0;
    for (int f = 0; f < 6; f++) begin
      for (int p = 0; p < 3; p++) begin
        emit_sw(0, 4 * k);
        emit(enc_b(13'd8, rb[p], ra[p], f3s[f]));
        emit_sw(11, 4 * k);
        e.push_back(branch_rule(f3s[f], val[p], valb[p]) ? 32'd0 : 32'd1);
        k++;
      end
    end
    emit(32'h0000_0073);
    load_and_reset();
    run_to_halt();
    check_slots(e);
  endtask

  task automatic test_sub_word();
    logic [7:0] bytes [4] = '{8'h81, 8'h72, 8'h93, 8'h24};
    logic [2:0] lf3 [8] = '{0, 4, 0, 4, 1, 5, 1, 5};
    int loff [8] = '{8'h40, 8'h40, 8'h42, 8'h43, 8'h44, 8'h44, 8'h46, 8'h46};
    strb_t es [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    word_t w [2];
    word_t e [$];
    word_t ea [$];
    word_t ed [$];
    word_t raw;
    word_t got;
    word_t mask;
    start_test("sub_word");
    for (int i = 0; i < 4; i++) begin
      emit_li(12, {24'd0, bytes[i]});
      emit(enc_s(12'(32'h40 + i), 12, 3'b000));
      ea.push_back(data_base + 32'h40);
      ed.push_back({24'd0, bytes[i]} << (8 * i));
    end
    emit_li(12, 32'h8001);
    emit(enc_s(12'h44, 12, 3'b001));
    emit_li(12, 32'h7ffe);
    emit(enc_s(12'h46, 12, 3'b001));
    ea.push_back(data_base + 32'h44);
    ea.push_back(data_base + 32'h44);
    ed.push_back(32'h0000_8001);
    ed.push_back(32'h7ffe_0000);
    w[0] = {bytes[3], bytes[2], bytes[1], bytes[0]};
    w[1] = 32'h7ffe_8001;
    for (int n = 0; n < 8; n++) begin
      emit(enc_i(loff[n][11:0], 31, lf3[n], 13, op_load));
      emit_sw(13, 8'h50 + 4 * n);
      raw = w[loff[n] / 4 - 16] >> (8 * (loff[n] % 4));
      e.push_back(extend(raw, lf3[n][0] ? 16 : 8, lf3[n][2]));
      ea.push_back(data_base + 32'h50 + 4 * n);
      ed.push_back(e[n]);
    end
    emit(32'h0000_0073);
    load_and_reset();
    run_to_halt();
    if (strb_log.size() != 14) begin
      fail_plain("wrong number of stores seen at the core ports");
    end
    for (int i = 0; i < 14; i++) begin
      check_strb($sformatf("store %0d strobes", i), (i < 6) ? es[i] : 4'b1111, strb_log[i]);
      check_word($sformatf("store %0d address", i), ea[i], addr_log[i]);
      mask = lane_mask(strb_log[i]);
      check_word($sformatf("store %0d data", i), ed[i] & mask, data_log[i] & mask);
    end
    for (int i = 0; i < 2; i++) begin
      read_word(data_base + 8'h40 + 4 * i, got);
      check_word($sformatf("merged word %0d", i), w[i], got);
    end
    for (int n = 0; n < 8; n++) begin
      read_word(data_base + 8'h50 + 4 * n, got);
      check_word($sformatf("load %0d", n), e[n], got);
    end
  endtask

  task automatic hold_check();
    word_t pc_h;
    pc_h = imem_addr;
    repeat (10) begin
      @(posedge clk);
      #1;
      check_word("halted pc", pc_h, imem_addr);
      check_strb("halted strb", 4'b0000, dmem_strb);
      check_bit("halt held", 1'b1, halt);
    end
  endtask

  task automatic test_halt();
    word_t got;
    start_test("ecall_halt");
    emit(enc_i(12'd7, 0, 3'b000, 1, op_reg_imm));
    emit(32'h0000_0073);
    emit_sw(1, 0);
    load_and_reset();
    run_to_halt();
    hold_check();
    if (strb_log.size() != 0) begin
      fail_plain("a store happened after ecall");
    end
    start_test("illegal_halt");
    emit(enc_i(12'd9, 0, 3'b000, 1, op_reg_imm));
    emit_sw(1, 0);
    emit(32'hffff_ffff);
    emit_sw(0, 0);
    emit(32'h0000_0073);
    load_and_reset();
    run_to_halt();
    hold_check();
    if (strb_log.size() != 1) begin
      fail_plain("a store happened after the illegal instruction");
    end
    read_word(data_base, got);
    check_word("slot 0", 32'd9, got);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    peek_addr = '0;
    cycles    = 0;
    seed      = 37;
    test_name = "init";
    @(posedge clk);
    #1;
    test_reset();
    test_alu();
    test_jumps();
    test_branches();
    test_sub_word();
    test_halt();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_pc_unit.sv
hw/rv_core.sv
verif/rv_mem_model.sv
verif/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINT      ?= --lint-only --timing
TOP       ?= rv_core_tb
FILELIST  ?= compile.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
